//--- common/z3_pkg.sv
// shared types and constants for the Zorro III slave; the config ROM holds nibbles already in bus form
`default_nettype none

package z3_pkg;

	// ------------------------------------------------------------
	// bus level types
	// ------------------------------------------------------------
	typedef logic [31:0] addr_t;
	// D31..D0 order
	typedef logic [31:0] data_t;
	// bit 3 strobes D31..D24
	typedef logic [3:0] be_t;
	typedef logic [1:0] fc_t;
	// address bits 31..16, window and config space select
	typedef logic [15:0] addr_hi_t;
	// low byte of the address inside config space
	typedef logic [7:0] cfg_off_t;
	typedef logic [3:0] cfg_nib_t;

	// cycle FSM states
	typedef enum logic [2:0] {
		IDLE,
		MATCH,
		DATA,
		WRITE_REQ,
		READ_REQ,
		READ_WAIT,
		DTACK
	} z3_state_t;

	// ------------------------------------------------------------
	// memory store and request path
	// ------------------------------------------------------------
	localparam int unsigned MEM_WORDS_W = 10;
	localparam int unsigned MEM_ACCESS_CYCLES = 4;
	localparam int unsigned ACC_CNT_W = $clog2(MEM_ACCESS_CYCLES + 1);
	localparam int unsigned FIFO_DEPTH = 2;
	localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [MEM_WORDS_W-1:0] word_idx_t;
	typedef logic [ACC_CNT_W-1:0] acc_cnt_t;
	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
	// one extra bit so a full FIFO can be told from an empty one
	typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

	// ------------------------------------------------------------
	// autoconfig
	// ------------------------------------------------------------
	localparam addr_hi_t CFG_SPACE_HI = 16'hFF00;
	localparam cfg_off_t CFG_REG_BASE = 8'h44;
	localparam cfg_off_t CFG_REG_SHUTUP = 8'h4C;

	// offsets 00..3C in steps of 4, left to right
	// type Z3 memory 64K, product, flags, reserved, manufacturer, serial
	localparam cfg_nib_t [0:15] CFG_ROM = {
		4'hA, 4'h1, 4'hF, 4'hE,
		4'hC, 4'hF, 4'hF, 4'hF,
		4'hE, 4'hD, 4'hC, 4'hB,
		4'hF, 4'hF, 4'hF, 4'hE
	};

endpackage

`default_nettype wire

//--- common/mem_req_if.sv
// one request channel with a read response; fields must hold while req_valid waits for req_ready
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import z3_pkg::*; ();

	// request side
	logic req_valid;
	logic req_ready;
	logic we;
	word_idx_t idx;
	data_t wdata;
	be_t be;

	// response side, one pulse per read, in request order
	logic rsp_valid;
	data_t rdata;

	modport producer (
		output req_valid, we, idx, wdata, be,
		input req_ready, rsp_valid, rdata
	);

	modport consumer (
		input req_valid, we, idx, wdata, be,
		output req_ready, rsp_valid, rdata
	);

endinterface

`default_nettype wire

//--- z3_bus/autoconfig.sv
// single board, one window; writes are taken at any time and the nibbles are not inverted here
`timescale 1ns/1ps
`default_nettype none

module autoconfig import z3_pkg::*; (
	input wire logic clk,
	input wire logic nIORST,
	input wire logic cfg_wr,
	input wire cfg_off_t cfg_offset,
	input wire data_t cfg_wdata,
	output cfg_nib_t cfg_rdata,
	output addr_hi_t base_hi,
	output logic configured,
	output logic cfgout_n_o
);

	logic shutup;

	// ------------------------------------------------------------
	// ROM read
	// ------------------------------------------------------------
	always_comb begin
		// 00..3C from the table, everything above reads as F
		if (cfg_offset[7:6] == 2'b00)
			cfg_rdata = CFG_ROM[cfg_offset[5:2]];
		else
			cfg_rdata = 4'hF;
	end

	// ------------------------------------------------------------
	// base address and shut-up
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_hi <= '0;
			configured <= 1'b0;
			shutup <= 1'b0;
		end else if (cfg_wr) begin
			// base taken from D31..D16
			if (cfg_offset == CFG_REG_BASE) begin
				base_hi <= cfg_wdata[31:16];
				configured <= 1'b1;
			end
			// board stays off the bus until reset
			if (cfg_offset == CFG_REG_SHUTUP)
				shutup <= 1'b1;
		end
	end

	// next slot gets its turn once this board is done
	assign cfgout_n_o = ~(configured | shutup);

endmodule

`default_nettype wire

//--- z3_bus/z3_cycle_fsm.sv
// address, read_i and fc_i must be stable until fcs is sampled low; no bus error, timeout or MTCR support
`timescale 1ns/1ps
`default_nettype none

module z3_cycle_fsm import z3_pkg::*; (
	input wire logic clk,
	input wire logic nIORST,
	input wire logic fcs_n_i,
	input wire logic doe_i,
	input wire logic read_i,
	input wire logic cfgin_n_i,
	input wire addr_t addr_i,
	input wire fc_t fc_i,
	input wire be_t ds_n_i,
	input wire data_t wdata_i,
	input wire addr_hi_t base_hi,
	input wire logic configured,
	input wire cfg_nib_t cfg_rdata,
	output logic cfg_wr,
	output cfg_off_t cfg_offset,
	output data_t cfg_wdata,
	output data_t rdata_o,
	output logic data_oe_o,
	output logic slave_n_o,
	output logic dtack_n_o,
	mem_req_if.producer up
);

	// ------------------------------------------------------------
	// strobe synchronizers
	// ------------------------------------------------------------
	logic fcs_s1, fcs_s2, fcs_d;
	logic doe_s1, doe_s2;
	be_t ds_s1, ds_s2;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_s1 <= 1'b1;
			fcs_s2 <= 1'b1;
			fcs_d <= 1'b1;
			doe_s1 <= 1'b0;
			doe_s2 <= 1'b0;
			ds_s1 <= '1;
			ds_s2 <= '1;
		end else begin
			fcs_s1 <= fcs_n_i;
			fcs_s2 <= fcs_s1;
			// edge detect only, not part of the synchronizer
			fcs_d <= fcs_s2;
			doe_s1 <= doe_i;
			doe_s2 <= doe_s1;
			ds_s1 <= ds_n_i;
			ds_s2 <= ds_s1;
		end
	end

	// first cycle with the synchronized fcs low
	logic fcs_fall;
	assign fcs_fall = ~fcs_s2 & fcs_d;

	// any data strobe asserted
	logic strobe;
	assign strobe = (ds_s2 != '1);

	// ------------------------------------------------------------
	// address decode, on the live bus lines
	// ------------------------------------------------------------
	logic fc_ok, cfg_hit, card_hit;

	// user/supervisor data or program space only
	assign fc_ok = fc_i[0] ^ fc_i[1];
	// config space only while unconfigured and selected by the chain
	assign cfg_hit = ~cfgin_n_i & ~configured & (addr_i[31:16] == CFG_SPACE_HI);
	assign card_hit = configured & (addr_i[31:16] == base_hi);

	// ------------------------------------------------------------
	// cycle FSM
	// ------------------------------------------------------------
	z3_state_t state, state_nx;
	addr_t addr_r;
	logic read_r;
	logic cfg_sel_r;

	always_comb begin
		state_nx = state;
		// master ends the cycle, from any state
		if (fcs_s2) begin
			state_nx = IDLE;
		end else begin
			case (state)
				IDLE:
					if (fcs_fall && fc_ok && (cfg_hit || card_hit))
						state_nx = MATCH;
				MATCH:
					// config reads answer straight from the ROM
					if (doe_s2)
						state_nx = (cfg_sel_r && read_r) ? DTACK : DATA;
				DATA:
					if (read_r)
						state_nx = READ_REQ;
					else if (strobe)
						state_nx = cfg_sel_r ? DTACK : WRITE_REQ;
				WRITE_REQ:
					// posted, dtack once the FIFO takes it
					if (up.req_ready)
						state_nx = DTACK;
				READ_REQ:
					if (up.req_ready)
						state_nx = READ_WAIT;
				READ_WAIT:
					// queued behind earlier writes, so this is the newest word
					if (up.rsp_valid)
						state_nx = DTACK;
				DTACK:
					state_nx = DTACK;
				default:
					state_nx = IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state <= IDLE;
			read_r <= 1'b0;
			cfg_sel_r <= 1'b0;
			slave_n_o <= 1'b1;
			dtack_n_o <= 1'b1;
			cfg_wr <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == IDLE && fcs_fall) begin
				read_r <= read_i;
				cfg_sel_r <= cfg_hit;
			end
			// both rise on the edge that sees fcs high again
			slave_n_o <= (state_nx == IDLE);
			dtack_n_o <= fcs_s2 | (state != DTACK);
			// one cycle pulse, data already in wdata_r
			cfg_wr <= ~fcs_s2 & (state == DATA) & ~read_r & strobe & cfg_sel_r;
		end
	end

	// ------------------------------------------------------------
	// payload registers
	// ------------------------------------------------------------
	data_t wdata_r;
	be_t be_r;

	always_ff @(posedge clk) begin
		if (state == IDLE && fcs_fall)
			addr_r <= addr_i;
		if (state == DATA) begin
			if (read_r) begin
				// full word on reads
				be_r <= '1;
			end else if (strobe) begin
				wdata_r <= wdata_i;
				be_r <= ~ds_s2;
			end
		end
		// read data lands one edge ahead of dtack
		if (state == MATCH && doe_s2 && cfg_sel_r && read_r)
			rdata_o <= {cfg_rdata, 28'hFFF_FFFF};
		else if (state == READ_WAIT && up.rsp_valid)
			rdata_o <= up.rdata;
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign cfg_offset = addr_r[7:0];
	assign cfg_wdata = wdata_r;

	assign data_oe_o = ~slave_n_o & doe_i & read_i;

	// store aliases inside the 64K window
	assign up.req_valid = (state == WRITE_REQ) || (state == READ_REQ);
	assign up.we = (state == WRITE_REQ);
	assign up.idx = addr_r[MEM_WORDS_W+1:2];
	assign up.wdata = wdata_r;
	assign up.be = be_r;

endmodule

`default_nettype wire

//--- src/req_fifo.sv
// in-order request buffer; read responses pass straight back and are not buffered
`timescale 1ns/1ps
`default_nettype none

module req_fifo import z3_pkg::*; (
	input wire logic clk,
	input wire logic nIORST,
	mem_req_if.consumer up,
	mem_req_if.producer down
);

	// entry storage
	logic we_q [FIFO_DEPTH];
	word_idx_t idx_q [FIFO_DEPTH];
	data_t wdata_q [FIFO_DEPTH];
	be_t be_q [FIFO_DEPTH];

	fifo_ptr_t wr_ptr, rd_ptr;
	fifo_cnt_t count;
	logic push, pop;

	// ------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------
	assign up.req_ready = (count != fifo_cnt_t'(FIFO_DEPTH));
	assign down.req_valid = (count != '0);
	assign push = up.req_valid & up.req_ready;
	assign pop = down.req_valid & down.req_ready;

	// head entry to the store
	assign down.we = we_q[rd_ptr];
	assign down.idx = idx_q[rd_ptr];
	assign down.wdata = wdata_q[rd_ptr];
	assign down.be = be_q[rd_ptr];

	// response pass-back, same cycle
	assign up.rsp_valid = down.rsp_valid;
	assign up.rdata = down.rdata;

	always_ff @(posedge clk) begin
		if (push) begin
			we_q[wr_ptr] <= up.we;
			idx_q[wr_ptr] <= up.idx;
			wdata_q[wr_ptr] <= up.wdata;
			be_q[wr_ptr] <= up.be;
		end
	end

	// ------------------------------------------------------------
	// pointers and fill level
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// push and pop together leave the level alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/mem_store.sv
// on-chip stand-in for the SDRAM controller; one access at a time, fixed latency, no refresh
`timescale 1ns/1ps
`default_nettype none

module mem_store import z3_pkg::*; (
	input wire logic clk,
	input wire logic nIORST,
	mem_req_if.consumer req
);

	data_t mem [2**MEM_WORDS_W];
	data_t rdata_r;
	acc_cnt_t busy_cnt;
	logic pend_read;
	logic accept;

	// ------------------------------------------------------------
	// access timing
	// ------------------------------------------------------------
	// idle when the counter has run out
	assign req.req_ready = (busy_cnt == '0);
	assign accept = req.req_valid & req.req_ready;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			busy_cnt <= '0;
			pend_read <= 1'b0;
		end else if (accept) begin
			busy_cnt <= acc_cnt_t'(MEM_ACCESS_CYCLES);
			pend_read <= ~req.we;
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// response in the last busy cycle, reads only
	assign req.rsp_valid = pend_read & (busy_cnt == acc_cnt_t'(1));
	assign req.rdata = rdata_r;

	// ------------------------------------------------------------
	// array access at accept time
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			if (req.we) begin
				// byte lanes, bit 3 is D31..D24
				for (int b = 0; b < $bits(be_t); b++) begin
					if (req.be[b])
						mem[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end else begin
				rdata_r <= mem[req.idx];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/z3_slave.sv
// top level; data bus split into wdata_i and rdata_o, data_oe_o drives the external buffers
`timescale 1ns/1ps
`default_nettype none

module z3_slave import z3_pkg::*; (
	input wire logic clk,
	input wire logic nIORST,
	input wire logic fcs_n_i,
	input wire logic doe_i,
	input wire logic read_i,
	input wire addr_t addr_i,
	input wire fc_t fc_i,
	input wire be_t ds_n_i,
	input wire data_t wdata_i,
	input wire logic cfgin_n_i,
	output data_t rdata_o,
	output logic data_oe_o,
	output logic slave_n_o,
	output logic dtack_n_o,
	output logic cfgout_n_o
);

	// FSM to autoconfig
	logic cfg_wr;
	cfg_off_t cfg_offset;
	data_t cfg_wdata;
	cfg_nib_t cfg_rdata;
	addr_hi_t base_hi;
	logic configured;

	// FSM to FIFO, FIFO to store
	mem_req_if up_if ();
	mem_req_if mem_if ();

	z3_cycle_fsm fsm0 (
		.clk (clk),
		.nIORST (nIORST),
		.fcs_n_i (fcs_n_i),
		.doe_i (doe_i),
		.read_i (read_i),
		.cfgin_n_i (cfgin_n_i),
		.addr_i (addr_i),
		.fc_i (fc_i),
		.ds_n_i (ds_n_i),
		.wdata_i (wdata_i),
		.base_hi (base_hi),
		.configured (configured),
		.cfg_rdata (cfg_rdata),
		.cfg_wr (cfg_wr),
		.cfg_offset (cfg_offset),
		.cfg_wdata (cfg_wdata),
		.rdata_o (rdata_o),
		.data_oe_o (data_oe_o),
		.slave_n_o (slave_n_o),
		.dtack_n_o (dtack_n_o),
		.up (up_if.producer)
	);

	autoconfig acfg0 (
		.clk (clk),
		.nIORST (nIORST),
		.cfg_wr (cfg_wr),
		.cfg_offset (cfg_offset),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.base_hi (base_hi),
		.configured (configured),
		.cfgout_n_o (cfgout_n_o)
	);

	req_fifo fifo0 (
		.clk (clk),
		.nIORST (nIORST),
		.up (up_if.consumer),
		.down (mem_if.producer)
	);

	mem_store store0 (
		.clk (clk),
		.nIORST (nIORST),
		.req (mem_if.consumer)
	);

endmodule

`default_nettype wire

//--- testbench/z3_bus_tasks.svh
// bus master and compare tasks; included inside tb_z3_slave after its signal declarations
`ifndef Z3_BUS_TASKS_SVH
`define Z3_BUS_TASKS_SVH

// ------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------
task automatic check_data(input string name, input data_t exp, input data_t act);
	if (act !== exp) begin
		$display("Error %s: expected %h, actual %h", name, exp, act);
		abort_run();
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("Error %s: expected %b, actual %b", name, exp, act);
		abort_run();
	end
endtask

// ------------------------------------------------------------
// bus master
// ------------------------------------------------------------
task automatic release_bus();
	@(posedge clk);
	fcs_n_i <= 1'b1;
	doe_i <= 1'b0;
	ds_n_i <= '1;
endtask

task automatic bus_cycle(input string name, input logic rd, input logic resp,
	input addr_t a, input fc_t fc, input be_t ds_n, input data_t wd, input data_t exp);
	int n;
	// address, strobes and data all valid with fcs
	@(posedge clk);
	addr_i <= a;
	fc_i <= fc;
	read_i <= rd;
	ds_n_i <= ds_n;
	wdata_i <= wd;
	doe_i <= 1'b1;
	fcs_n_i <= 1'b0;
	if (!resp) begin
		// nobody may answer
		repeat (40) begin
			@(negedge clk);
			check_flag({name, " slave_n"}, 1'b1, slave_n_o);
			check_flag({name, " dtack_n"}, 1'b1, dtack_n_o);
			check_flag({name, " data_oe"}, 1'b0, data_oe_o);
		end
		release_bus();
		// let the synchronizers see fcs high
		repeat (3) @(negedge clk);
	end else begin
		// first negedge follows the drive edge, so edge 3 is count 4
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (slave_n_o && n < 40);
		if (slave_n_o) begin
			$display("%s: no slave response within 40 cycles", name);
			abort_run();
		end else if (n != 4) begin
			$display("%s: slave_n_o fell %0d edges after fcs, not 3", name, n - 1);
			abort_run();
		end
		n = 0;
		while (dtack_n_o && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (dtack_n_o) begin
			$display("%s: dtack_n_o did not fall within 40 cycles", name);
			abort_run();
		end
		check_flag({name, " slave_n at dtack"}, 1'b0, slave_n_o);
		check_flag({name, " data_oe"}, rd, data_oe_o);
		// read word already stable at dtack
		if (rd)
			check_data(name, exp, rdata_o);
		release_bus();
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (!slave_n_o)
				check_flag({name, " dtack_n held"}, 1'b0, dtack_n_o);
		end while (!slave_n_o && n < 40);
		if (!slave_n_o) begin
			$display("%s: slave_n_o stayed low after fcs was released", name);
			abort_run();
		end
		// rises on the same edge as slave
		check_flag({name, " dtack_n release"}, 1'b1, dtack_n_o);
	end
endtask

// ------------------------------------------------------------
// one case file line
// ------------------------------------------------------------
task automatic run_case(input string name, input case_t c);
	logic rd;
	logic resp;
	rd = (c.kind == "CR") || (c.kind == "MR") || (c.kind == "NR");
	resp = (c.kind != "NR") && (c.kind != "NW");
	bus_cycle(name, rd, resp, c.addr, c.fc, c.ds_n, c.wdata, c.exp);
	// config chain passed on once the base is taken
	if (c.kind == "CW")
		check_flag({name, " cfgout_n"}, c.exp[0], cfgout_n_o);
endtask

`endif

//--- testbench/tb_z3_slave.sv
// run from the project root so testbench/z3_cases.txt is found; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_z3_slave import z3_pkg::*; ();

	// one line of the case file
	typedef struct packed {
		logic [127:0] name;
		logic [15:0] kind;
		addr_t addr;
		fc_t fc;
		be_t ds_n;
		data_t wdata;
		data_t exp;
	} case_t;

	// ------------------------------------------------------------
	// clock, DUT signals
	// ------------------------------------------------------------
	logic clk = 1'b0;
	logic nIORST;
	logic fcs_n_i;
	logic doe_i;
	logic read_i;
	addr_t addr_i;
	fc_t fc_i;
	be_t ds_n_i;
	data_t wdata_i;
	logic cfgin_n_i;
	data_t rdata_o;
	logic data_oe_o;
	logic slave_n_o;
	logic dtack_n_o;
	logic cfgout_n_o;

	case_t cases[$];
	int n_cases = 0;

	// 8 ns period
	always #4 clk = ~clk;

	z3_slave dut0 (
		.clk (clk),
		.nIORST (nIORST),
		.fcs_n_i (fcs_n_i),
		.doe_i (doe_i),
		.read_i (read_i),
		.addr_i (addr_i),
		.fc_i (fc_i),
		.ds_n_i (ds_n_i),
		.wdata_i (wdata_i),
		.cfgin_n_i (cfgin_n_i),
		.rdata_o (rdata_o),
		.data_oe_o (data_oe_o),
		.slave_n_o (slave_n_o),
		.dtack_n_o (dtack_n_o),
		.cfgout_n_o (cfgout_n_o)
	);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	// numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_cases();
		int fd;
		int n;
		string line;
		logic [127:0] nm;
		logic [15:0] kd;
		addr_t a;
		fc_t f;
		be_t d;
		data_t w;
		data_t e;
		case_t row;
		fd = $fopen("testbench/z3_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/z3_cases.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// blank and comment lines
			if (n <= 1 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %h %h %h", nm, kd, a, f, d, w, e);
			if (n != 7) begin
				$display("malformed case line: %s", line);
				abort_run();
			end
			row = '{nm, kd, a, f, d, w, e};
			cases.push_back(row);
		end
		$fclose(fd);
	endtask

	`include "z3_bus_tasks.svh"

	// ------------------------------------------------------------
	// watchdog, 64 cycles per case plus reset
	// ------------------------------------------------------------
	initial begin
		wait (n_cases != 0);
		#((n_cases * 64 + 8) * 8);
		$display("watchdog expired after %0d cycles, run did not finish", n_cases * 64 + 8);
		abort_run();
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] seed;
		string name;
		int gap;
		// bus idle, first board in the chain
		nIORST = 1'b0;
		fcs_n_i = 1'b1;
		doe_i = 1'b0;
		read_i = 1'b0;
		addr_i = '0;
		fc_i = '0;
		ds_n_i = '1;
		wdata_i = '0;
		cfgin_n_i = 1'b0;
		seed = 32'h12ed_d23b;
		load_cases();
		if (cases.size() == 0) begin
			$display("case file holds no cases");
			abort_run();
		end
		n_cases = cases.size();
		repeat (8) @(posedge clk);
		nIORST <= 1'b1;
		// bus outputs and config chain idle out of reset
		@(negedge clk);
		check_flag("reset slave_n", 1'b1, slave_n_o);
		check_flag("reset dtack_n", 1'b1, dtack_n_o);
		check_flag("reset cfgout_n", 1'b1, cfgout_n_o);
		foreach (cases[i]) begin
			name = $sformatf("%0s", cases[i].name);
			// 0 to 7 idle cycles between bus cycles
			seed = lcg_next(seed);
			gap = int'(seed[18:16]);
			repeat (gap) @(posedge clk);
			run_case(name, cases[i]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- z3_slave.f
+incdir+testbench
common/z3_pkg.sv
common/mem_req_if.sv
z3_bus/autoconfig.sv
z3_bus/z3_cycle_fsm.sv
src/req_fifo.sv
src/mem_store.sv
src/z3_slave.sv
testbench/tb_z3_slave.sv

//--- run_sim.sh
#!/bin/sh
# build the Zorro III slave testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f z3_slave.f --top-module tb_z3_slave -o tb_z3_slave
out=$(./obj_dir/tb_z3_slave 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

//--- testbench/z3_cases.txt
# name kind addr fc ds_n wdata exp, all hex; ds_n active low, bit 3 strobes D31..D24
# kind CR/CW config read/write, MR/MW card read/write, NR/NW no answer due; CW exp is cfgout_n
pre_card NR 40000000 1 0 00000000 00000000
cfg_fc0 NR FF000000 0 0 00000000 00000000
cfg_fc3 NR FF000000 3 0 00000000 00000000
cfg_rd_00 CR FF000000 1 0 00000000 AFFFFFFF
cfg_rd_04 CR FF000004 1 0 00000000 1FFFFFFF
cfg_rd_08 CR FF000008 2 0 00000000 FFFFFFFF
cfg_rd_0c CR FF00000C 1 0 00000000 EFFFFFFF
cfg_rd_10 CR FF000010 1 0 00000000 CFFFFFFF
cfg_rd_14 CR FF000014 2 0 00000000 FFFFFFFF
cfg_rd_18 CR FF000018 1 0 00000000 FFFFFFFF
cfg_rd_1c CR FF00001C 1 0 00000000 FFFFFFFF
cfg_rd_20 CR FF000020 1 0 00000000 EFFFFFFF
cfg_rd_24 CR FF000024 2 0 00000000 DFFFFFFF
cfg_rd_28 CR FF000028 1 0 00000000 CFFFFFFF
cfg_rd_2c CR FF00002C 1 0 00000000 BFFFFFFF
cfg_rd_30 CR FF000030 1 0 00000000 FFFFFFFF
cfg_rd_34 CR FF000034 2 0 00000000 FFFFFFFF
cfg_rd_38 CR FF000038 1 0 00000000 FFFFFFFF
cfg_rd_3c CR FF00003C 1 0 00000000 EFFFFFFF
cfg_base CW FF000044 1 0 40000000 00000000
cfg_after NR FF000000 1 0 00000000 00000000
wr_w0 MW 40000000 1 0 12345678 00000000
wr_w1 MW 40000004 2 0 89ABCDEF 00000000
rd_w0 MR 40000000 1 0 00000000 12345678
rd_w1 MR 40000004 1 0 00000000 89ABCDEF
part_w0 MW 40000000 1 5 AABBCCDD 00000000
part_r0 MR 40000000 1 0 00000000 AA34CC78
part_w1 MW 40000004 1 E 00000011 00000000
part_r1 MR 40000004 2 0 00000000 89ABCD11
burst_w0 MW 40000010 1 0 11111111 00000000
burst_w1 MW 40000010 1 0 22222222 00000000
burst_w2 MW 40000010 1 0 33333333 00000000
burst_w3 MW 40000010 1 0 44444444 00000000
burst_rd MR 40000010 1 0 00000000 44444444
alias_rd MR 40001010 1 0 00000000 44444444
out_win NR 40010000 1 0 00000000 00000000
fc_eq_wr NW 40000000 0 0 DEADBEEF 00000000
keep_rd MR 40000000 1 0 00000000 AA34CC78
